/* Makefile */
TOP := mini6502_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f mini6502.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* mini6502.f */
source/mini6502_pkg.sv
source/mini6502_alu.sv
source/mini6502_decode.sv
source/mini6502_sequencer.sv
source/mini6502_datapath.sv
source/mini6502_top.sv
verif/mini6502_tb.sv

/* source/mini6502_alu.sv */
`timescale 1ns/1ps

module mini6502_alu (
    input  mini6502_pkg::byte_t   i_a,
    input  mini6502_pkg::byte_t   i_b,
    input  logic                  i_carry,
    input  mini6502_pkg::alu_op_e i_op,
    output mini6502_pkg::byte_t   o_result,
    output logic                  o_carry,
    output logic                  o_zero
);

    logic [8:0] sum;  // carry out lives in bit 8

    always_comb begin
        sum      = 9'd0;
        o_result = i_b;      // pass by default
        o_carry  = i_carry;  // only add and subtract touch the carry
        case (i_op)
            mini6502_pkg::ALU_ADC: begin
                sum      = {1'b0, i_a} + {1'b0, i_b} + {8'd0, i_carry};
                o_result = sum[7:0];
                o_carry  = sum[8];
            end
            mini6502_pkg::ALU_SBC: begin
                // carry set means no borrow
                sum      = {1'b0, i_a} + {1'b0, ~i_b} + {8'd0, i_carry};
                o_result = sum[7:0];
                o_carry  = sum[8];
            end
            mini6502_pkg::ALU_AND: o_result = i_a & i_b;
            mini6502_pkg::ALU_ORA: o_result = i_a | i_b;
            mini6502_pkg::ALU_EOR: o_result = i_a ^ i_b;
            mini6502_pkg::ALU_INC: o_result = i_b + 8'd1;
            mini6502_pkg::ALU_DEC: o_result = i_b - 8'd1;
            default:               o_result = i_b;
        endcase
    end

    assign o_zero = (o_result == 8'h00);

endmodule

/* source/mini6502_datapath.sv */
`timescale 1ns/1ps

module mini6502_datapath (
    input  logic                i_clk,
    input  logic                i_rst,
    input  mini6502_pkg::byte_t i_data,
    input  mini6502_pkg::ctrl_t i_ctrl,
    input  logic                i_exec,
    output mini6502_pkg::byte_t o_store_data,
    output logic                o_flag_c,
    output logic                o_flag_z
);

    mini6502_pkg::byte_t reg_a;
    mini6502_pkg::byte_t reg_x;
    mini6502_pkg::byte_t reg_y;
    mini6502_pkg::byte_t alu_a;
    mini6502_pkg::byte_t alu_b;
    mini6502_pkg::byte_t alu_result;
    logic                alu_carry;
    logic                alu_zero;

    function automatic mini6502_pkg::byte_t pick(input mini6502_pkg::reg_sel_e sel,
                                                 input mini6502_pkg::byte_t a,
                                                 input mini6502_pkg::byte_t x,
                                                 input mini6502_pkg::byte_t y,
                                                 input mini6502_pkg::byte_t mem);
        case (sel)
            mini6502_pkg::REG_A:   return a;
            mini6502_pkg::REG_X:   return x;
            mini6502_pkg::REG_Y:   return y;
            mini6502_pkg::REG_MEM: return mem;
            default:               return 8'h00;
        endcase
    endfunction

    assign alu_a        = pick(i_ctrl.a_src, reg_a, reg_x, reg_y, i_data);
    assign alu_b        = pick(i_ctrl.b_src, reg_a, reg_x, reg_y, i_data);
    assign o_store_data = alu_b;  // stores name their register as b

    mini6502_alu u_alu (
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_carry  (o_flag_c),
        .i_op     (i_ctrl.alu_op),
        .o_result (alu_result),
        .o_carry  (alu_carry),
        .o_zero   (alu_zero)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            reg_a    <= 8'h00;
            reg_x    <= 8'h00;
            reg_y    <= 8'h00;
            o_flag_c <= 1'b0;
            o_flag_z <= 1'b0;
        end else if (i_exec) begin
            case (i_ctrl.dst)
                mini6502_pkg::REG_A: reg_a <= alu_result;
                mini6502_pkg::REG_X: reg_x <= alu_result;
                mini6502_pkg::REG_Y: reg_y <= alu_result;
                default:             reg_a <= reg_a;
            endcase
            if (i_ctrl.sets_flags) begin
                o_flag_c <= alu_carry;  // unchanged except for adc and sbc
                o_flag_z <= alu_zero;
            end
            if (i_ctrl.set_carry) begin
                o_flag_c <= 1'b1;
            end else if (i_ctrl.clear_carry) begin
                o_flag_c <= 1'b0;
            end
        end
    end

endmodule

/* source/mini6502_decode.sv */
`timescale 1ns/1ps

module mini6502_decode (
    input  mini6502_pkg::byte_t i_opcode,
    output mini6502_pkg::ctrl_t o_ctrl
);

    mini6502_pkg::addr_mode_e rd_mode;
    mini6502_pkg::reg_sel_e   low_reg;
    mini6502_pkg::alu_op_e    logic_op;

    function automatic mini6502_pkg::ctrl_t idle_ctrl();
        mini6502_pkg::ctrl_t c;
        c.mode        = mini6502_pkg::IMPLIED;
        c.a_src       = mini6502_pkg::REG_NONE;
        c.b_src       = mini6502_pkg::REG_NONE;
        c.dst         = mini6502_pkg::REG_NONE;
        c.alu_op      = mini6502_pkg::ALU_PASS;
        c.cond        = mini6502_pkg::COND_EQ;
        c.set_carry   = 1'b0;
        c.clear_carry = 1'b0;
        c.sets_flags  = 1'b0;
        c.illegal     = 1'b0;
        return c;
    endfunction

    // register move through the alu, flags follow the result
    function automatic mini6502_pkg::ctrl_t reg_op(input mini6502_pkg::addr_mode_e mode,
                                                   input mini6502_pkg::reg_sel_e   src,
                                                   input mini6502_pkg::reg_sel_e   dst,
                                                   input mini6502_pkg::alu_op_e    op);
        mini6502_pkg::ctrl_t c;
        c            = idle_ctrl();
        c.mode       = mode;
        c.b_src      = src;
        c.dst        = dst;
        c.alu_op     = op;
        c.sets_flags = 1'b1;
        return c;
    endfunction

    assign rd_mode = i_opcode[2] ? mini6502_pkg::ZPG_READ : mini6502_pkg::IMMEDIATE;

    // loads and stores name their register in bits 1:0
    assign low_reg = (i_opcode[1:0] == 2'b01) ? mini6502_pkg::REG_A :
                     i_opcode[1]              ? mini6502_pkg::REG_X : mini6502_pkg::REG_Y;

    always_comb begin
        case (i_opcode[7:5])
            3'b011:  logic_op = mini6502_pkg::ALU_ADC;
            3'b111:  logic_op = mini6502_pkg::ALU_SBC;
            3'b001:  logic_op = mini6502_pkg::ALU_AND;
            3'b010:  logic_op = mini6502_pkg::ALU_EOR;
            default: logic_op = mini6502_pkg::ALU_ORA;
        endcase
    end

    always_comb begin
        o_ctrl = idle_ctrl();
        case (i_opcode)
            8'hA9, 8'hA5, 8'hA2, 8'hA6, 8'hA0, 8'hA4: begin  // lda ldx ldy
                o_ctrl = reg_op(rd_mode, mini6502_pkg::REG_MEM, low_reg, mini6502_pkg::ALU_PASS);
            end
            8'h85, 8'h86, 8'h84: begin                       // sta stx sty
                o_ctrl.mode  = mini6502_pkg::ZPG_WRITE;
                o_ctrl.b_src = low_reg;
            end
            8'h69, 8'h65, 8'hE9, 8'hE5, 8'h29, 8'h25,
            8'h09, 8'h05, 8'h49, 8'h45: begin                // adc sbc and ora eor
                o_ctrl = reg_op(rd_mode, mini6502_pkg::REG_MEM, mini6502_pkg::REG_A, logic_op);
                o_ctrl.a_src = mini6502_pkg::REG_A;
            end
            8'h18: o_ctrl.clear_carry = 1'b1;                // clc
            8'h38: o_ctrl.set_carry   = 1'b1;                // sec
            8'hAA: o_ctrl = reg_op(mini6502_pkg::IMPLIED, mini6502_pkg::REG_A,
                                   mini6502_pkg::REG_X, mini6502_pkg::ALU_PASS);
            8'hA8: o_ctrl = reg_op(mini6502_pkg::IMPLIED, mini6502_pkg::REG_A,
                                   mini6502_pkg::REG_Y, mini6502_pkg::ALU_PASS);
            8'h8A: o_ctrl = reg_op(mini6502_pkg::IMPLIED, mini6502_pkg::REG_X,
                                   mini6502_pkg::REG_A, mini6502_pkg::ALU_PASS);
            8'h98: o_ctrl = reg_op(mini6502_pkg::IMPLIED, mini6502_pkg::REG_Y,
                                   mini6502_pkg::REG_A, mini6502_pkg::ALU_PASS);
            8'hE8: o_ctrl = reg_op(mini6502_pkg::IMPLIED, mini6502_pkg::REG_X,
                                   mini6502_pkg::REG_X, mini6502_pkg::ALU_INC);
            8'hC8: o_ctrl = reg_op(mini6502_pkg::IMPLIED, mini6502_pkg::REG_Y,
                                   mini6502_pkg::REG_Y, mini6502_pkg::ALU_INC);
            8'hCA: o_ctrl = reg_op(mini6502_pkg::IMPLIED, mini6502_pkg::REG_X,
                                   mini6502_pkg::REG_X, mini6502_pkg::ALU_DEC);
            8'h88: o_ctrl = reg_op(mini6502_pkg::IMPLIED, mini6502_pkg::REG_Y,
                                   mini6502_pkg::REG_Y, mini6502_pkg::ALU_DEC);
            8'h4C: o_ctrl.mode = mini6502_pkg::JUMP_ABS;
            8'hF0, 8'hD0, 8'h90, 8'hB0: begin
                o_ctrl.mode = mini6502_pkg::BRANCH;
                case (i_opcode[7:5])
                    3'b111:  o_ctrl.cond = mini6502_pkg::COND_EQ;  // beq
                    3'b110:  o_ctrl.cond = mini6502_pkg::COND_NE;  // bne
                    3'b100:  o_ctrl.cond = mini6502_pkg::COND_CC;  // bcc
                    default: o_ctrl.cond = mini6502_pkg::COND_CS;  // bcs
                endcase
            end
            default: o_ctrl.illegal = 1'b1;
        endcase
    end

endmodule

/* source/mini6502_pkg.sv */
package mini6502_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    localparam addr_t RESET_PC  = 16'h0200;  // first opcode fetched after reset
    localparam byte_t ZERO_PAGE = 8'h00;     // high byte of every zero-page access

    typedef enum logic [2:0] {
        IMPLIED,
        IMMEDIATE,
        ZPG_READ,
        ZPG_WRITE,
        JUMP_ABS,
        BRANCH
    } addr_mode_e;

    typedef enum logic [2:0] {
        REG_A,
        REG_X,
        REG_Y,
        REG_MEM,   // byte on the read data bus
        REG_NONE
    } reg_sel_e;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADC,
        ALU_SBC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_INC,
        ALU_DEC
    } alu_op_e;

    typedef enum logic [1:0] {
        COND_EQ,
        COND_NE,
        COND_CC,
        COND_CS
    } branch_cond_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_OPERAND,
        S_ZPG,
        S_JMP_HI,
        S_JAM
    } state_e;

    typedef struct packed {
        addr_mode_e   mode;
        reg_sel_e     a_src;        // alu input a
        reg_sel_e     b_src;        // alu input b, also the store source
        reg_sel_e     dst;          // register written on execute
        alu_op_e      alu_op;
        branch_cond_e cond;
        logic         set_carry;    // sec
        logic         clear_carry;  // clc
        logic         sets_flags;   // take carry and zero from the alu
        logic         illegal;
    } ctrl_t;

endpackage

/* source/mini6502_sequencer.sv */
`timescale 1ns/1ps

module mini6502_sequencer (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  mini6502_pkg::byte_t   i_data,
    input  mini6502_pkg::ctrl_t   i_ctrl,
    input  logic                  i_flag_c,
    input  logic                  i_flag_z,
    output mini6502_pkg::byte_t   o_opcode,
    output mini6502_pkg::addr_t   o_addr,
    output logic                  o_rw,
    output logic                  o_sync,
    output logic                  o_jam,
    output logic                  o_exec
);

    mini6502_pkg::state_e state;
    mini6502_pkg::addr_t  pc;
    mini6502_pkg::addr_t  branch_target;
    mini6502_pkg::byte_t  ir;
    mini6502_pkg::byte_t  operand;  // zero-page address or jump low byte
    logic                 taken;

    // the opcode is decoded straight off the bus in the cycle it arrives
    assign o_opcode = (state == mini6502_pkg::S_DECODE) ? i_data : ir;

    // pc already points past the offset byte
    assign branch_target = pc + {{8{i_data[7]}}, i_data};

    always_comb begin
        case (i_ctrl.cond)
            mini6502_pkg::COND_EQ: taken = i_flag_z;
            mini6502_pkg::COND_NE: taken = !i_flag_z;
            mini6502_pkg::COND_CC: taken = !i_flag_c;
            default:               taken = i_flag_c;
        endcase
    end

    always_comb begin
        o_addr = pc;
        o_rw   = 1'b1;
        o_sync = 1'b0;
        o_jam  = 1'b0;
        o_exec = 1'b0;
        case (state)
            mini6502_pkg::S_FETCH:   o_sync = 1'b1;
            mini6502_pkg::S_DECODE: begin
                o_exec = !i_ctrl.illegal && (i_ctrl.mode == mini6502_pkg::IMPLIED);
            end
            mini6502_pkg::S_OPERAND: begin
                if (i_ctrl.mode == mini6502_pkg::IMMEDIATE) begin
                    o_exec = 1'b1;
                end else if (i_ctrl.mode == mini6502_pkg::ZPG_READ ||
                             i_ctrl.mode == mini6502_pkg::ZPG_WRITE) begin
                    o_addr = {mini6502_pkg::ZERO_PAGE, i_data};
                    o_rw   = (i_ctrl.mode != mini6502_pkg::ZPG_WRITE);
                end
            end
            mini6502_pkg::S_ZPG: begin
                o_addr = {mini6502_pkg::ZERO_PAGE, operand};  // read data returns now
                o_exec = 1'b1;
            end
            mini6502_pkg::S_JAM:     o_jam = 1'b1;
            default:                 o_addr = pc;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= mini6502_pkg::S_FETCH;
            pc    <= mini6502_pkg::RESET_PC;
            ir    <= 8'h00;
        end else begin
            case (state)
                mini6502_pkg::S_FETCH: begin
                    pc    <= pc + 16'd1;
                    state <= mini6502_pkg::S_DECODE;
                end
                mini6502_pkg::S_DECODE: begin
                    ir <= i_data;
                    if (i_ctrl.illegal) begin
                        state <= mini6502_pkg::S_JAM;
                    end else if (i_ctrl.mode == mini6502_pkg::IMPLIED) begin
                        state <= mini6502_pkg::S_FETCH;
                    end else begin
                        pc    <= pc + 16'd1;  // step over the operand byte
                        state <= mini6502_pkg::S_OPERAND;
                    end
                end
                mini6502_pkg::S_OPERAND: begin
                    case (i_ctrl.mode)
                        mini6502_pkg::ZPG_READ: state <= mini6502_pkg::S_ZPG;
                        mini6502_pkg::JUMP_ABS: state <= mini6502_pkg::S_JMP_HI;
                        mini6502_pkg::BRANCH: begin
                            if (taken) begin
                                pc <= branch_target;
                            end
                            state <= mini6502_pkg::S_FETCH;
                        end
                        default:                state <= mini6502_pkg::S_FETCH;
                    endcase
                end
                mini6502_pkg::S_ZPG:     state <= mini6502_pkg::S_FETCH;
                mini6502_pkg::S_JMP_HI: begin
                    pc    <= {i_data, operand};
                    state <= mini6502_pkg::S_FETCH;
                end
                default:                 state <= mini6502_pkg::S_JAM;  // held until reset
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == mini6502_pkg::S_OPERAND) begin
            operand <= i_data;
        end
    end

endmodule

/* source/mini6502_top.sv */
`timescale 1ns/1ps

module mini6502_top (
    input  logic                i_clk,
    input  logic                i_rst,
    input  mini6502_pkg::byte_t i_data,
    output mini6502_pkg::addr_t o_addr,
    output mini6502_pkg::byte_t o_dout,
    output logic                o_rw,
    output logic                o_sync,
    output logic                o_jam
);

    mini6502_pkg::byte_t opcode;
    mini6502_pkg::ctrl_t ctrl;
    logic                exec;
    logic                flag_c;
    logic                flag_z;

    mini6502_sequencer u_sequencer (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_data   (i_data),
        .i_ctrl   (ctrl),
        .i_flag_c (flag_c),
        .i_flag_z (flag_z),
        .o_opcode (opcode),
        .o_addr   (o_addr),
        .o_rw     (o_rw),
        .o_sync   (o_sync),
        .o_jam    (o_jam),
        .o_exec   (exec)
    );

    mini6502_decode u_decode (
        .i_opcode (opcode),
        .o_ctrl   (ctrl)
    );

    mini6502_datapath u_datapath (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_data       (i_data),
        .i_ctrl       (ctrl),
        .i_exec       (exec),
        .o_store_data (o_dout),
        .o_flag_c     (flag_c),
        .o_flag_z     (flag_z)
    );

endmodule

/* verif/mini6502_tb.sv */
`timescale 1ns/1ps

module mini6502_tb;

    logic                i_clk;
    logic                i_rst;
    mini6502_pkg::byte_t i_data;
    mini6502_pkg::addr_t o_addr;
    mini6502_pkg::byte_t o_dout;
    logic                o_rw;
    logic                o_sync;
    logic                o_jam;

    logic [7:0]  mem [0:65535];
    logic [7:0]  prog [$];      // program image, placed at the reset address
    logic [15:0] bus_addr;
    logic [7:0]  bus_dout;
    logic        bus_rw;
    int          write_count;
    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    mini6502_top u_mini6502_top (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_data (i_data),
        .o_addr (o_addr),
        .o_dout (o_dout),
        .o_rw   (o_rw),
        .o_sync (o_sync),
        .o_jam  (o_jam)
    );

    always #2 i_clk = ~i_clk;  // 4 ns period

    always @(negedge i_clk) begin  // bus settled mid-cycle
        bus_addr = o_addr;
        bus_rw   = o_rw;
        bus_dout = o_dout;
    end

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return {a[11:8], a[15:12]} ^ a[7:0] ^ 8'hC3;
    endfunction

    function automatic logic [15:0] prog_addr();
        return mini6502_pkg::RESET_PC + 16'(prog.size());
    endfunction

    // one cycle read latency, write at the edge ending a write cycle
    task automatic serve_memory();
        logic [7:0] rd;
        forever begin
            @(posedge i_clk);
            if (bus_rw == 1'b0) begin
                mem[bus_addr] = bus_dout;
                write_count++;
            end
            rd = mem[bus_addr];
            #1;
            i_data = rd;
        end
    endtask

    task automatic put_byte(input logic [7:0] b);
        prog.push_back(b);
    endtask

    task automatic put_op(input logic [7:0] op, input logic [7:0] arg);
        prog.push_back(op);
        prog.push_back(arg);
    endtask

    task automatic put_jump(input logic [15:0] target);
        put_byte(8'h4C);
        put_byte(target[7:0]);
        put_byte(target[15:8]);
    endtask

    task automatic load_program();
        int idx;
        i_rst = 1'b1;
        for (idx = 0; idx < 65536; idx++) begin
            mem[idx] = fill_byte(16'(idx));
        end
        for (idx = 0; idx < prog.size(); idx++) begin
            mem[mini6502_pkg::RESET_PC + 16'(idx)] = prog[idx];
        end
        prog.delete();
    endtask

    task automatic release_reset();
        repeat (16) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
    endtask

    // a jmp to itself shows as two syncs at one address
    task automatic run_to_halt(input string name);
        int          cycles;
        logic [15:0] last;
        logic        seen;
        logic        done;
        cycles = 0;
        seen   = 1'b0;
        done   = 1'b0;
        last   = 16'h0000;
        while (!done && cycles < 1000) begin
            @(negedge i_clk);
            cycles++;
            if (o_jam) begin
                errors++;
                $display("%s: the core jammed at %0t ns", name, $time);
                done = 1'b1;
            end else if (o_sync) begin
                done = seen && (o_addr == last);
                last = o_addr;
                seen = 1'b1;
            end
        end
        if (!done) begin
            errors++;
            $display("%s: timed out waiting for the final self-jump", name);
        end
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_mem(input logic [15:0] addr, input logic [7:0] exp,
                             input string what);
        checks++;
        if (mem[addr] !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, mem[%h] = %h, expected %h",
                     $time, what, addr, mem[addr], exp);
        end
    endtask

    task automatic test_load_store();
        logic [7:0] v [6];
        int         i;
        for (i = 0; i < 6; i++) begin
            v[i] = rand_byte();
        end
        put_op(8'hA9, v[0]);  // lda #
        put_op(8'h85, 8'h40);
        put_op(8'hA2, v[1]);  // ldx #
        put_op(8'h86, 8'h41);
        put_op(8'hA0, v[2]);  // ldy #
        put_op(8'h84, 8'h42);
        put_op(8'hA5, 8'h10);  // zero-page loads
        put_op(8'h85, 8'h43);
        put_op(8'hA6, 8'h11);
        put_op(8'h86, 8'h44);
        put_op(8'hA4, 8'h12);
        put_op(8'h84, 8'h45);
        put_jump(prog_addr());
        load_program();
        mem[16'h0010] = v[3];
        mem[16'h0011] = v[4];
        mem[16'h0012] = v[5];
        release_reset();
        run_to_halt("load/store");
        for (i = 0; i < 6; i++) begin
            check_mem(16'h0040 + 16'(i), v[i], "load/store");
        end
    endtask

    task automatic test_alu();
        logic [7:0] a, b, c, d, e, f, g;
        logic [8:0] sum1;
        logic [7:0] sum2;
        a = rand_byte() | 8'h80;  // both high bits set forces a carry out
        b = rand_byte() | 8'h80;
        c = rand_byte();
        d = rand_byte();
        e = rand_byte();
        f = rand_byte();
        g = rand_byte();
        sum1 = {1'b0, a} + {1'b0, b};
        sum2 = sum1[7:0] + c + {7'd0, sum1[8]};
        put_byte(8'h38);  // set carry first so clc has work to do
        put_byte(8'h18);  // clc
        put_op(8'hA9, a);
        put_op(8'h69, b);
        put_op(8'h85, 8'h50);
        put_op(8'h65, 8'h20);  // adc zero page, takes the carry
        put_op(8'h85, 8'h51);
        put_byte(8'h38);  // sec
        put_op(8'hA9, d);
        put_op(8'hE9, e);
        put_op(8'h85, 8'h52);
        put_op(8'hA9, f);
        put_op(8'h29, g);
        put_op(8'h85, 8'h53);
        put_op(8'hA9, f);
        put_op(8'h05, 8'h21);
        put_op(8'h85, 8'h54);
        put_op(8'hA9, f);
        put_op(8'h49, g);
        put_op(8'h85, 8'h55);
        put_jump(prog_addr());
        load_program();
        mem[16'h0020] = c;
        mem[16'h0021] = g;
        release_reset();
        run_to_halt("alu");
        check_mem(16'h0050, sum1[7:0], "adc sum");
        check_mem(16'h0051, sum2, "adc with carry in");
        check_mem(16'h0052, 8'(d - e), "sbc difference");
        check_mem(16'h0053, f & g, "and");
        check_mem(16'h0054, f | g, "ora");
        check_mem(16'h0055, f ^ g, "eor");
    endtask

    task automatic test_transfers();
        logic [7:0] v;
        v = rand_byte();
        put_op(8'hA9, v);
        put_byte(8'hAA);  // tax
        put_byte(8'hE8);  // inx
        put_op(8'h86, 8'h60);
        put_byte(8'hA8);  // tay
        put_byte(8'h88);  // dey
        put_op(8'h84, 8'h61);
        put_byte(8'h8A);  // txa
        put_op(8'h85, 8'h62);
        put_op(8'hA0, 8'h00);
        put_byte(8'h88);
        put_op(8'h84, 8'h63);
        put_byte(8'h98);  // tya
        put_op(8'h85, 8'h65);
        put_op(8'hA2, 8'hFF);
        put_byte(8'hE8);
        put_op(8'h86, 8'h64);
        put_jump(prog_addr());
        load_program();
        release_reset();
        run_to_halt("transfers");
        check_mem(16'h0060, v + 8'd1, "tax then inx");
        check_mem(16'h0061, v - 8'd1, "tay then dey");
        check_mem(16'h0062, v + 8'd1, "txa");
        check_mem(16'h0063, 8'hFF, "dey from zero");
        check_mem(16'h0064, 8'h00, "inx from ff");
        check_mem(16'h0065, 8'hFF, "tya");
    endtask

    task automatic test_branches();
        logic [7:0]  n;
        logic [15:0] target;
        n = (rand_byte() & 8'h0F) | 8'h01;
        put_op(8'hA2, n);
        put_op(8'hA0, 8'h00);
        put_byte(8'hC8);  // loop: iny
        put_byte(8'hCA);  // dex
        put_op(8'hD0, 8'hFC);  // bne back to iny
        put_op(8'h84, 8'h70);
        put_op(8'hA9, 8'h3C);  // marker
        put_byte(8'h38);
        put_op(8'hB0, 8'h02);  // bcs over the next store
        put_op(8'h85, 8'h71);
        put_op(8'h90, 8'h02);  // bcc falls through
        put_op(8'h85, 8'h72);
        put_op(8'hA9, 8'h00);
        put_op(8'hF0, 8'h02);  // beq over the next store
        put_op(8'h85, 8'h73);
        target = prog_addr() + 16'd5;
        put_jump(target);
        put_op(8'h85, 8'h74);
        put_jump(prog_addr());
        load_program();
        release_reset();
        run_to_halt("branches");
        check_mem(16'h0070, n, "countdown loop");
        check_mem(16'h0071, fill_byte(16'h0071), "bcs taken");
        check_mem(16'h0072, 8'h3C, "bcc not taken");
        check_mem(16'h0073, fill_byte(16'h0073), "beq taken");
        check_mem(16'h0074, fill_byte(16'h0074), "jmp over a store");
    endtask

    task automatic test_jam();
        logic [7:0] v;
        int         cycles;
        int         writes;
        v = rand_byte();
        put_op(8'hA9, v);
        put_op(8'h85, 8'h30);
        put_byte(8'h02);  // not a kept opcode
        load_program();
        release_reset();
        cycles = 0;
        while (!o_jam && cycles < 50) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_jam) begin
            errors++;
            $display("jam: o_jam did not rise within 50 cycles");
        end else begin
            writes = write_count;
            for (cycles = 0; cycles < 20; cycles++) begin
                @(negedge i_clk);
                checks++;
                if (!o_jam || o_sync || !o_rw) begin
                    errors++;
                    $display("CHECK FAILED at %0t ns: jam cycle %0d, jam %b sync %b rw %b",
                             $time, cycles, o_jam, o_sync, o_rw);
                end
            end
            checks++;
            if (write_count != writes) begin
                errors++;
                $display("CHECK FAILED at %0t ns: memory written while jammed", $time);
            end
        end
        @(posedge i_clk);
        #1;
        check_mem(16'h0030, v, "store before the illegal opcode");
        i_rst = 1'b1;
        release_reset();
        @(negedge i_clk);
        checks++;
        if (o_jam || !o_sync) begin
            errors++;
            $display("CHECK FAILED at %0t ns: after reset jam %b sync %b, expected 0 and 1",
                     $time, o_jam, o_sync);
        end
        @(posedge i_clk);
        #1;
    endtask

    task automatic run_tests();
        @(posedge i_clk);
        #1;
        test_load_store();
        test_alu();
        test_transfers();
        test_branches();
        test_jam();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        i_clk       = 1'b0;
        i_rst       = 1'b1;
        i_data      = 8'h00;
        bus_addr    = 16'h0000;
        bus_dout    = 8'h00;
        bus_rw      = 1'b1;
        write_count = 0;
        errors      = 0;
        checks      = 0;
        lcg_state   = 32'hb9d034d5;
        fork
            serve_memory();
            run_tests();
        join_any
    end

endmodule
